//--- common/core_cfg_pkg.sv
package core_cfg_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int BE_W      = XLEN / 8;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [XLEN-1:0]      addr_t;    // Byte address
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [BE_W-1:0]      be_t;

  localparam int DEF_TCM_WORDS = 1024;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQUEST,
    FETCH_HOLD
  } fetch_state_t;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_WAIT,
    LSU_DONE  // Halted after ECALL
  } lsu_state_t;

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // Major opcodes of the supported subset
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // ALU function codes, shared by OP_REG and OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct3_t F3_LW  = 3'b010; // Word access only
  localparam funct3_t F3_SW  = 3'b010;
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B // LUI immediate straight through
  } alu_op_t;

endpackage

//--- fetch/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                clock,
  input  logic                rst_n,
  input  core_cfg_pkg::word_t icache_data,
  input  logic                icache_waitrequest,
  input  logic                inst_accept,
  input  logic                next_pc_valid,
  input  core_cfg_pkg::addr_t next_pc,
  output core_cfg_pkg::addr_t icache_addr,
  output logic                icache_rd,
  output logic                inst_valid,
  output rv_isa_pkg::inst_t   inst,
  output core_cfg_pkg::addr_t pc
);

  core_cfg_pkg::fetch_state_t state;
  logic                       boot_q; // First fetch from pc 0 after reset

  // Read starts in the same cycle next_pc arrives to save a cycle
  assign icache_rd   = (state == core_cfg_pkg::FETCH_REQUEST) ||
                       (state == core_cfg_pkg::FETCH_IDLE && next_pc_valid);
  assign icache_addr = (state == core_cfg_pkg::FETCH_IDLE) ? next_pc : pc;
  assign inst_valid  = (state == core_cfg_pkg::FETCH_HOLD);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state  <= core_cfg_pkg::FETCH_IDLE;
      pc     <= '0;
      boot_q <= 1'b1;
    end else begin
      boot_q <= 1'b0;
      case (state)
        core_cfg_pkg::FETCH_IDLE: begin
          if (next_pc_valid) begin
            pc    <= next_pc;
            state <= core_cfg_pkg::FETCH_REQUEST;
          end else if (boot_q) begin
            state <= core_cfg_pkg::FETCH_REQUEST;
          end
        end
        core_cfg_pkg::FETCH_REQUEST: begin
          if (!icache_waitrequest) state <= core_cfg_pkg::FETCH_HOLD;
        end
        core_cfg_pkg::FETCH_HOLD: begin
          if (inst_accept) state <= core_cfg_pkg::FETCH_IDLE;
        end
        default: state <= core_cfg_pkg::FETCH_IDLE;
      endcase
    end
  end

  // Instruction holding register
  always_ff @(posedge clock) begin
    if (state == core_cfg_pkg::FETCH_REQUEST && !icache_waitrequest) begin
      inst <= icache_data;
    end
  end

endmodule

//--- execute/decode_execute.sv
`timescale 1ns/1ps

module decode_execute (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   inst_valid,
  input  rv_isa_pkg::inst_t      inst,
  input  core_cfg_pkg::addr_t    pc,
  input  core_cfg_pkg::word_t    rd_data1,
  input  core_cfg_pkg::word_t    rd_data2,
  output logic                   inst_accept,
  output core_cfg_pkg::reg_idx_t rd_addr1,
  output core_cfg_pkg::reg_idx_t rd_addr2,
  output logic                   exec_valid,
  output core_cfg_pkg::word_t    result,
  output core_cfg_pkg::addr_t    mem_addr,
  output core_cfg_pkg::word_t    store_data,
  output logic                   is_load,
  output logic                   is_store,
  output core_cfg_pkg::reg_idx_t dest,
  output logic                   dest_valid,
  output core_cfg_pkg::addr_t    next_pc,
  output logic                   is_halt
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  core_cfg_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  core_cfg_pkg::word_t op_b, alu_out;
  core_cfg_pkg::addr_t pc_plus4, next_pc_c;
  rv_isa_pkg::alu_op_t alu_op;
  logic                dv_c, ld_c, st_c, br_c, jal_c, halt_c, taken;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign rd_addr1 = inst[19:15];
  assign rd_addr2 = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // One instruction in flight, so accept whatever fetch presents
  assign inst_accept = inst_valid;

  always_comb begin
    alu_op = rv_isa_pkg::ALU_ADD;
    op_b   = rd_data2;
    dv_c   = 1'b0;
    ld_c   = 1'b0;
    st_c   = 1'b0;
    br_c   = 1'b0;
    jal_c  = 1'b0;
    halt_c = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_REG: begin
        dv_c = 1'b1;
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: begin
            if (funct7 == rv_isa_pkg::F7_SUB) alu_op = rv_isa_pkg::ALU_SUB;
          end
          rv_isa_pkg::F3_SLT: alu_op = rv_isa_pkg::ALU_SLT;
          rv_isa_pkg::F3_XOR: alu_op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::ALU_AND;
          default: dv_c = 1'b0; // Shifts and SLTU not supported
        endcase
      end
      rv_isa_pkg::OP_IMM: begin
        op_b = imm_i;
        dv_c = (funct3 == rv_isa_pkg::F3_ADD_SUB); // ADDI only
      end
      rv_isa_pkg::OP_LUI: begin
        alu_op = rv_isa_pkg::ALU_PASS_B;
        op_b   = imm_u;
        dv_c   = 1'b1;
      end
      rv_isa_pkg::OP_LOAD: begin
        op_b = imm_i;
        ld_c = 1'b1;
        dv_c = 1'b1;
      end
      rv_isa_pkg::OP_STORE: begin
        op_b = imm_s;
        st_c = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: br_c = 1'b1;
      rv_isa_pkg::OP_JAL: begin
        jal_c = 1'b1;
        dv_c  = 1'b1;
      end
      rv_isa_pkg::OP_SYSTEM: halt_c = 1'b1;
      default: ;             // No-operation
    endcase
  end

  always_comb begin
    case (alu_op)
      rv_isa_pkg::ALU_SUB:    alu_out = rd_data1 - op_b;
      rv_isa_pkg::ALU_AND:    alu_out = rd_data1 & op_b;
      rv_isa_pkg::ALU_OR:     alu_out = rd_data1 | op_b;
      rv_isa_pkg::ALU_XOR:    alu_out = rd_data1 ^ op_b;
      rv_isa_pkg::ALU_SLT:    alu_out = {31'b0, $signed(rd_data1) < $signed(op_b)};
      rv_isa_pkg::ALU_PASS_B: alu_out = op_b;
      default:                alu_out = rd_data1 + op_b;
    endcase
  end

  assign taken = br_c && ((funct3 == rv_isa_pkg::F3_BEQ && rd_data1 == rd_data2) ||
                          (funct3 == rv_isa_pkg::F3_BNE && rd_data1 != rd_data2));

  assign pc_plus4  = pc + 32'd4;
  assign next_pc_c = jal_c ? pc + imm_j :
                     taken ? pc + imm_b : pc_plus4;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) exec_valid <= 1'b0;
    else        exec_valid <= inst_valid;
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      result     <= jal_c ? pc_plus4 : alu_out; // Link value for JAL
      mem_addr   <= alu_out;
      store_data <= rd_data2;
      is_load    <= ld_c;
      is_store   <= st_c;
      dest       <= inst[11:7];
      dest_valid <= dv_c;
      next_pc    <= next_pc_c;
      is_halt    <= halt_c;
    end
  end

endmodule

//--- load_store/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   exec_valid,
  input  core_cfg_pkg::word_t    result,
  input  core_cfg_pkg::addr_t    mem_addr,
  input  core_cfg_pkg::word_t    store_data,
  input  logic                   is_load,
  input  logic                   is_store,
  input  core_cfg_pkg::reg_idx_t dest,
  input  logic                   dest_valid,
  input  core_cfg_pkg::addr_t    next_pc,
  input  logic                   is_halt,
  input  core_cfg_pkg::word_t    dcache_data,
  input  logic                   dcache_waitrequest,
  output core_cfg_pkg::addr_t    dcache_addr,
  output logic                   dcache_rd,
  output logic                   dcache_wr,
  output core_cfg_pkg::be_t      dcache_wr_be,
  output core_cfg_pkg::word_t    dcache_wr_data,
  output logic                   wr_enable1,
  output core_cfg_pkg::reg_idx_t wr_addr1,
  output core_cfg_pkg::word_t    wr_data1,
  output logic                   retire_valid,
  output core_cfg_pkg::reg_idx_t retire_rd,
  output core_cfg_pkg::word_t    retire_data,
  output logic                   next_pc_valid,
  output core_cfg_pkg::addr_t    next_pc_out,
  output logic                   halted
);

  core_cfg_pkg::lsu_state_t state;
  core_cfg_pkg::addr_t      addr_q, next_pc_q;
  core_cfg_pkg::reg_idx_t   dest_q;
  logic                     dest_valid_q;

  logic                     in_idle, in_wait, fire, do_write;
  core_cfg_pkg::reg_idx_t   sel_dest;
  core_cfg_pkg::word_t      sel_value;

  assign in_idle = (state == core_cfg_pkg::LSU_IDLE);
  assign in_wait = (state == core_cfg_pkg::LSU_WAIT);

  // Load holds its request from the latched copy during the wait state
  assign dcache_rd      = (in_idle && exec_valid && is_load) || in_wait;
  assign dcache_wr      = in_idle && exec_valid && is_store;
  assign dcache_addr    = in_wait ? addr_q : mem_addr;
  assign dcache_wr_be   = '1;  // Word stores only
  assign dcache_wr_data = store_data;

  // Retire source is either the load return or the execute result
  assign fire      = in_wait ? !dcache_waitrequest : (in_idle && exec_valid && !is_load);
  assign sel_dest  = in_wait ? dest_q : dest;
  assign sel_value = in_wait ? dcache_data : result;
  assign do_write  = fire && (in_wait ? dest_valid_q : dest_valid) && (sel_dest != '0);

  assign retire_rd   = wr_addr1;
  assign retire_data = wr_data1;
  assign halted      = (state == core_cfg_pkg::LSU_DONE);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state         <= core_cfg_pkg::LSU_IDLE;
      wr_enable1    <= 1'b0;
      retire_valid  <= 1'b0;
      next_pc_valid <= 1'b0;
    end else begin
      wr_enable1    <= do_write;
      retire_valid  <= fire;
      next_pc_valid <= fire && !(in_idle && is_halt); // No next fetch after ECALL
      if (in_idle && exec_valid) begin
        if (is_load)      state <= core_cfg_pkg::LSU_WAIT;
        else if (is_halt) state <= core_cfg_pkg::LSU_DONE;
      end else if (in_wait && !dcache_waitrequest) begin
        state <= core_cfg_pkg::LSU_IDLE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (in_idle && exec_valid && is_load) begin
      addr_q       <= mem_addr;
      dest_q       <= dest;
      dest_valid_q <= dest_valid;
      next_pc_q    <= next_pc;
    end
    if (fire) begin
      wr_addr1    <= do_write ? sel_dest : '0;
      wr_data1    <= do_write ? sel_value : '0;
      next_pc_out <= in_wait ? next_pc_q : next_pc;
    end
  end

endmodule

//--- source/rfile.sv
`timescale 1ns/1ps

module rfile (
  input  logic                   clock,
  input  logic                   rst_n,
  input  core_cfg_pkg::reg_idx_t rd_addr1,
  input  core_cfg_pkg::reg_idx_t rd_addr2,
  input  core_cfg_pkg::reg_idx_t wr_addr1,
  input  logic                   wr_enable1,
  input  core_cfg_pkg::word_t    wr_data1,
  output core_cfg_pkg::word_t    rd_data1,
  output core_cfg_pkg::word_t    rd_data2
);

  core_cfg_pkg::word_t regs [32];

  // Asynchronous reads, x0 hardwired to zero
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_enable1 && wr_addr1 != '0) begin
      regs[wr_addr1] <= wr_data1;
    end
  end

endmodule

//--- source/tcm.sv
`timescale 1ns/1ps

module tcm #(
  parameter int TCM_WORDS = core_cfg_pkg::DEF_TCM_WORDS
) (
  input  logic                clock,
  input  logic                rst_n,
  input  core_cfg_pkg::addr_t cpu_addr,
  input  logic                cpu_rd,
  input  logic                cpu_wr,
  input  core_cfg_pkg::be_t   cpu_be,
  input  core_cfg_pkg::word_t cpu_wr_data,
  input  logic                load_en,
  input  core_cfg_pkg::addr_t load_addr,   // Word index
  input  core_cfg_pkg::word_t load_data,
  output core_cfg_pkg::word_t cpu_rd_data,
  output logic                cpu_waitrequest
);

  localparam int IDX_W = $clog2(TCM_WORDS);

  core_cfg_pkg::word_t mem [TCM_WORDS];
  logic [IDX_W-1:0]    cpu_idx;
  logic                rd_ack_q;  // Data valid in second cycle of a read

  assign cpu_idx         = cpu_addr[IDX_W+1:2];
  assign cpu_waitrequest = cpu_rd && !rd_ack_q;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) rd_ack_q <= 1'b0;
    else        rd_ack_q <= cpu_rd && !rd_ack_q;
  end

  always_ff @(posedge clock) begin
    if (cpu_rd && !rd_ack_q) cpu_rd_data <= mem[cpu_idx];
    if (load_en) begin
      mem[load_addr[IDX_W-1:0]] <= load_data; // Boot load wins
    end else if (cpu_wr) begin
      for (int b = 0; b < core_cfg_pkg::BE_W; b++) begin
        if (cpu_be[b]) mem[cpu_idx][b*8 +: 8] <= cpu_wr_data[b*8 +: 8];
      end
    end
  end

endmodule

//--- source/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter int TCM_WORDS = core_cfg_pkg::DEF_TCM_WORDS
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   imem_load_en,
  input  core_cfg_pkg::addr_t    imem_load_addr,
  input  core_cfg_pkg::word_t    imem_load_data,
  input  logic                   dmem_load_en,
  input  core_cfg_pkg::addr_t    dmem_load_addr,
  input  core_cfg_pkg::word_t    dmem_load_data,
  output logic                   retire_valid,
  output core_cfg_pkg::reg_idx_t retire_rd,
  output core_cfg_pkg::word_t    retire_data,
  output logic                   halted
);

  // Instruction side
  core_cfg_pkg::addr_t    icache_addr;
  logic                   icache_rd, icache_waitrequest;
  core_cfg_pkg::word_t    icache_data;
  logic                   inst_valid, inst_accept;
  rv_isa_pkg::inst_t      inst;
  core_cfg_pkg::addr_t    pc;

  // Register file
  core_cfg_pkg::reg_idx_t rf_rd_addr1, rf_rd_addr2, rf_wr_addr1;
  core_cfg_pkg::word_t    rf_rd_data1, rf_rd_data2, rf_wr_data1;
  logic                   rf_wr_enable1;

  // Execute results
  logic                   exec_valid, ex_is_load, ex_is_store, ex_dest_valid, ex_is_halt;
  core_cfg_pkg::word_t    ex_result, ex_store_data;
  core_cfg_pkg::addr_t    ex_mem_addr, ex_next_pc;
  core_cfg_pkg::reg_idx_t ex_dest;

  // Data side and PC return
  core_cfg_pkg::addr_t    dcache_addr;
  logic                   dcache_rd, dcache_wr, dcache_waitrequest;
  core_cfg_pkg::be_t      dcache_wr_be;
  core_cfg_pkg::word_t    dcache_wr_data, dcache_data;
  logic                   next_pc_valid;
  core_cfg_pkg::addr_t    next_pc;

  fetch_unit u_fetch (
    .clock              (clock),
    .rst_n              (rst_n),
    .icache_data        (icache_data),
    .icache_waitrequest (icache_waitrequest),
    .inst_accept        (inst_accept),
    .next_pc_valid      (next_pc_valid),
    .next_pc            (next_pc),
    .icache_addr        (icache_addr),
    .icache_rd          (icache_rd),
    .inst_valid         (inst_valid),
    .inst               (inst),
    .pc                 (pc)
  );

  decode_execute u_execute (
    .clock       (clock),
    .rst_n       (rst_n),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .pc          (pc),
    .rd_data1    (rf_rd_data1),
    .rd_data2    (rf_rd_data2),
    .inst_accept (inst_accept),
    .rd_addr1    (rf_rd_addr1),
    .rd_addr2    (rf_rd_addr2),
    .exec_valid  (exec_valid),
    .result      (ex_result),
    .mem_addr    (ex_mem_addr),
    .store_data  (ex_store_data),
    .is_load     (ex_is_load),
    .is_store    (ex_is_store),
    .dest        (ex_dest),
    .dest_valid  (ex_dest_valid),
    .next_pc     (ex_next_pc),
    .is_halt     (ex_is_halt)
  );

  load_store_unit u_lsu (
    .clock              (clock),
    .rst_n              (rst_n),
    .exec_valid         (exec_valid),
    .result             (ex_result),
    .mem_addr           (ex_mem_addr),
    .store_data         (ex_store_data),
    .is_load            (ex_is_load),
    .is_store           (ex_is_store),
    .dest               (ex_dest),
    .dest_valid         (ex_dest_valid),
    .next_pc            (ex_next_pc),
    .is_halt            (ex_is_halt),
    .dcache_data        (dcache_data),
    .dcache_waitrequest (dcache_waitrequest),
    .dcache_addr        (dcache_addr),
    .dcache_rd          (dcache_rd),
    .dcache_wr          (dcache_wr),
    .dcache_wr_be       (dcache_wr_be),
    .dcache_wr_data     (dcache_wr_data),
    .wr_enable1         (rf_wr_enable1),
    .wr_addr1           (rf_wr_addr1),
    .wr_data1           (rf_wr_data1),
    .retire_valid       (retire_valid),
    .retire_rd          (retire_rd),
    .retire_data        (retire_data),
    .next_pc_valid      (next_pc_valid),
    .next_pc_out        (next_pc),
    .halted             (halted)
  );

  rfile u_rfile (
    .clock      (clock),
    .rst_n      (rst_n),
    .rd_addr1   (rf_rd_addr1),
    .rd_addr2   (rf_rd_addr2),
    .wr_addr1   (rf_wr_addr1),
    .wr_enable1 (rf_wr_enable1),
    .wr_data1   (rf_wr_data1),
    .rd_data1   (rf_rd_data1),
    .rd_data2   (rf_rd_data2)
  );

  // ITCM is read-only from the core
  tcm #(.TCM_WORDS(TCM_WORDS)) itcm (
    .clock           (clock),
    .rst_n           (rst_n),
    .cpu_addr        (icache_addr),
    .cpu_rd          (icache_rd),
    .cpu_wr          (1'b0),
    .cpu_be          ('0),
    .cpu_wr_data     ('0),
    .load_en         (imem_load_en),
    .load_addr       (imem_load_addr),
    .load_data       (imem_load_data),
    .cpu_rd_data     (icache_data),
    .cpu_waitrequest (icache_waitrequest)
  );

  tcm #(.TCM_WORDS(TCM_WORDS)) dtcm (
    .clock           (clock),
    .rst_n           (rst_n),
    .cpu_addr        (dcache_addr),
    .cpu_rd          (dcache_rd),
    .cpu_wr          (dcache_wr),
    .cpu_be          (dcache_wr_be),
    .cpu_wr_data     (dcache_wr_data),
    .load_en         (dmem_load_en),
    .load_addr       (dmem_load_addr),
    .load_data       (dmem_load_data),
    .cpu_rd_data     (dcache_data),
    .cpu_waitrequest (dcache_waitrequest)
  );

endmodule

//--- verification/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;

  localparam int TCM_WORDS    = 1024;
  localparam int PROG_LEN     = 200;
  localparam int DMEM_WORDS   = 64;
  localparam int RESET_CYCLES = 16;
  localparam int HALT_TIMEOUT = 5000;
  localparam int QUIET_CYCLES = 50;

  logic                   clock = 1'b0;
  logic                   rst_n;
  logic                   imem_load_en;
  core_cfg_pkg::addr_t    imem_load_addr;
  core_cfg_pkg::word_t    imem_load_data;
  logic                   dmem_load_en;
  core_cfg_pkg::addr_t    dmem_load_addr;
  core_cfg_pkg::word_t    dmem_load_data;
  logic                   retire_valid;
  core_cfg_pkg::reg_idx_t retire_rd;
  core_cfg_pkg::word_t    retire_data;
  logic                   halted;

  logic [31:0]            lfsr;
  rv_isa_pkg::inst_t      prog [256];
  core_cfg_pkg::reg_idx_t exp_rd [$];   // Expected retire stream from the ISA model
  core_cfg_pkg::word_t    exp_data [$];
  core_cfg_pkg::reg_idx_t want_rd;
  core_cfg_pkg::word_t    want_data;
  int                     errors = 0;
  int                     checks = 0;
  int                     n_retired = 0;

  core_top #(.TCM_WORDS(TCM_WORDS)) dut (
    .clock          (clock),
    .rst_n          (rst_n),
    .imem_load_en   (imem_load_en),
    .imem_load_addr (imem_load_addr),
    .imem_load_data (imem_load_data),
    .dmem_load_en   (dmem_load_en),
    .dmem_load_addr (dmem_load_addr),
    .dmem_load_data (dmem_load_data),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .halted         (halted)
  );

  always #5 clock = ~clock;

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ({1'b0, s[31:1]} ^ 32'h80200003) : {1'b0, s[31:1]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_SW, imm[4:0], rv_isa_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
  endfunction

  // Random program over x0..x7, ends with ECALL
  function automatic void build_program();
    logic [3:0]  kind;
    logic [4:0]  rd, rs1, rs2;
    logic [7:0]  off, last_st;
    logic        have_st;
    int          skip;
    have_st = 1'b0;
    last_st = 8'h00;
    for (int i = 0; i < 256; i++) prog[i[7:0]] = {25'b0, rv_isa_pkg::OP_SYSTEM};
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind = 4'(rand_bits(4));
      rd   = 5'(rand_bits(3));
      rs1  = 5'(rand_bits(3));
      rs2  = 5'(rand_bits(3));
      skip = 2 + int'(rand_bits(1));         // Forward 2 or 3 instructions
      if (kind >= 4'd13 && i > PROG_LEN - 4) kind = 4'd6;
      case (kind)
        4'd0: prog[i[7:0]] = enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_ADD_SUB, rd);
        4'd1: prog[i[7:0]] = enc_r(rv_isa_pkg::F7_SUB, rs2, rs1, rv_isa_pkg::F3_ADD_SUB, rd);
        4'd2: prog[i[7:0]] = enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_AND, rd);
        4'd3: prog[i[7:0]] = enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_OR, rd);
        4'd4: prog[i[7:0]] = enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_XOR, rd);
        4'd5: prog[i[7:0]] = enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_SLT, rd);
        4'd8: prog[i[7:0]] = {20'(rand_bits(20)), rd, rv_isa_pkg::OP_LUI};
        4'd9, 4'd10: begin
          // Often reread the last stored word
          off = {6'(rand_bits(6)), 2'b00};
          if (have_st && rand_bits(1) == 32'd1) off = last_st;
          prog[i[7:0]] = enc_i({4'b0, off}, 5'd0, rv_isa_pkg::F3_LW, rd, rv_isa_pkg::OP_LOAD);
        end
        4'd11, 4'd12: begin
          off          = {6'(rand_bits(6)), 2'b00};
          last_st      = off;
          have_st      = 1'b1;
          prog[i[7:0]] = enc_s({4'b0, off}, rs2, 5'd0);
        end
        4'd13: prog[i[7:0]] = enc_b(13'(skip * 4), rs2, rs1, rv_isa_pkg::F3_BEQ);
        4'd14: prog[i[7:0]] = enc_b(13'(skip * 4), rs2, rs1, rv_isa_pkg::F3_BNE);
        4'd15: prog[i[7:0]] = enc_j(21'(skip * 4), rd);
        default: prog[i[7:0]] = enc_i(12'(rand_bits(12)), rs1, rv_isa_pkg::F3_ADD_SUB, rd,
                                      rv_isa_pkg::OP_IMM);
      endcase
    end
  endfunction

  // ISA model, one expected (rd, data) entry per retired instruction
  function automatic void run_model();
    core_cfg_pkg::word_t regs [32];
    core_cfg_pkg::word_t dmem [DMEM_WORDS];
    core_cfg_pkg::addr_t pc, npc, addr;
    rv_isa_pkg::inst_t   ins;
    core_cfg_pkg::word_t a, b, val, imm_i, imm_s, imm_b, imm_j;
    logic [4:0]          rd;
    logic [2:0]          f3;
    logic                wr, halt;
    int                  steps;
    for (int k = 0; k < 32; k++) regs[k] = '0;
    for (int k = 0; k < DMEM_WORDS; k++) dmem[k] = '0;
    pc    = '0;
    halt  = 1'b0;
    steps = 0;
    while (!halt && steps < 4 * PROG_LEN) begin
      ins   = prog[pc[9:2]];
      rd    = ins[11:7];
      f3    = ins[14:12];
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      wr    = 1'b0;
      val   = '0;
      npc   = pc + 32'd4;
      case (ins[6:0])
        rv_isa_pkg::OP_REG: begin
          wr = 1'b1;
          case (f3)
            rv_isa_pkg::F3_ADD_SUB: val = (ins[31:25] == rv_isa_pkg::F7_SUB) ? a - b : a + b;
            rv_isa_pkg::F3_SLT:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::F3_XOR:     val = a ^ b;
            rv_isa_pkg::F3_OR:      val = a | b;
            rv_isa_pkg::F3_AND:     val = a & b;
            default:                wr = 1'b0;
          endcase
        end
        rv_isa_pkg::OP_IMM: begin
          wr  = (f3 == rv_isa_pkg::F3_ADD_SUB);
          val = a + imm_i;
        end
        rv_isa_pkg::OP_LUI: begin
          wr  = 1'b1;
          val = {ins[31:12], 12'b0};
        end
        rv_isa_pkg::OP_LOAD: begin
          addr = a + imm_i;
          wr   = 1'b1;
          val  = dmem[addr[7:2]];
        end
        rv_isa_pkg::OP_STORE: begin
          addr             = a + imm_s;
          dmem[addr[7:2]] = b;
        end
        rv_isa_pkg::OP_BRANCH: begin
          if ((f3 == rv_isa_pkg::F3_BEQ && a == b) || (f3 == rv_isa_pkg::F3_BNE && a != b))
            npc = pc + imm_b;
        end
        rv_isa_pkg::OP_JAL: begin
          wr  = 1'b1;
          val = pc + 32'd4;                  // Link value
          npc = pc + imm_j;
        end
        rv_isa_pkg::OP_SYSTEM: halt = 1'b1;
        default: ;
      endcase
      if (wr && rd != 5'd0) regs[rd] = val;
      exp_rd.push_back((wr && rd != 5'd0) ? rd : 5'd0);
      exp_data.push_back((wr && rd != 5'd0) ? val : 32'd0);
      pc    = npc;
      steps = steps + 1;
    end
  endfunction

  // Retire comparator, sampled mid-cycle
  always @(negedge clock) begin
    if (!rst_n) begin
      assert (!retire_valid && !halted) else begin
        $display("FAILED %0t: retire_valid or halted high during reset", $time);
        errors++;
      end
    end else if (retire_valid) begin
      assert (exp_rd.size() != 0) else begin
        $display("Retire at %0t after the model program already ended", $time);
        errors++;
      end
      if (exp_rd.size() != 0) begin
        want_rd   = exp_rd.pop_front();
        want_data = exp_data.pop_front();
        checks++;
        assert (retire_rd == want_rd && retire_data == want_data) else begin
          $display("FAILED %0t: retire %0d gave rd %0d data %h, expected rd %0d data %h",
                   $time, n_retired, retire_rd, retire_data, want_rd, want_data);
          errors++;
        end
        if (exp_rd.size() != 0) begin
          assert (!halted) else begin
            $display("FAILED %0t: halted high before the final instruction", $time);
            errors++;
          end
        end
      end
      n_retired++;
    end else if (n_retired == 0) begin
      assert (!halted) else begin
        $display("FAILED %0t: halted high before any instruction retired", $time);
        errors++;
      end
    end
  end

  initial begin
    int cyc;
    int retired_at_halt;
    int exp_total;
    rst_n          = 1'b0;
    imem_load_en   = 1'b0;
    imem_load_addr = '0;
    imem_load_data = '0;
    dmem_load_en   = 1'b0;
    dmem_load_addr = '0;
    dmem_load_data = '0;
    lfsr           = 32'hb364;
    build_program();
    run_model();
    exp_total = exp_rd.size();

    // Boot load while the core sits in reset
    for (int i = 0; i < PROG_LEN; i++) begin
      @(negedge clock);
      imem_load_en   = 1'b1;
      imem_load_addr = 32'(i);
      imem_load_data = prog[i[7:0]];
      dmem_load_en   = (i < DMEM_WORDS);
      dmem_load_addr = 32'(i);
      dmem_load_data = '0;
    end
    @(negedge clock);
    imem_load_en = 1'b0;
    dmem_load_en = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock);
    rst_n = 1'b1;

    cyc = 0;
    while (!halted && cyc < HALT_TIMEOUT) begin
      @(negedge clock);
      cyc++;
    end
    if (!halted) begin
      $display("Timeout: core did not halt within %0d cycles", HALT_TIMEOUT);
      errors++;
    end else begin
      @(posedge clock);
      retired_at_halt = n_retired;
      cyc = 0;
      while (cyc < QUIET_CYCLES) begin   // No retire allowed once halted
        @(negedge clock);
        cyc++;
      end
      @(posedge clock);
      checks++;
      assert (n_retired == retired_at_halt && halted) else begin
        $display("FAILED %0t: activity after halt, retired %0d then %0d",
                 $time, retired_at_halt, n_retired);
        errors++;
      end
    end
    checks++;
    assert (n_retired == exp_total) else begin
      $display("FAILED %0t: retired %0d instructions, model retired %0d",
               $time, n_retired, exp_total);
      errors++;
    end

    $display("Checks: %0d  errors: %0d  retired: %0d of %0d",
             checks, errors, n_retired, exp_total);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
common/core_cfg_pkg.sv
common/rv_isa_pkg.sv
fetch/fetch_unit.sv
execute/decode_execute.sv
load_store/load_store_unit.sv
source/rfile.sv
source/tcm.sv
source/core_top.sv
verification/tb_core_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run from the project root, pass is judged from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core_top -f src.f -o sim_core_top \
  && ./obj_dir/sim_core_top > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "^SIMULATION PASSED$" sim.log 2>/dev/null \
  || { echo "Simulation did not pass"; exit 1; }
exit 0
